// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= rv64_decode.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/ctrl_decode.sv
// opcode decoder
// opcode to immediate format, register enables, ALU overrides and flags
// unknown opcodes come out flagged illegal
module ctrl_decode
    import isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    // word ops only exist on a 64-bit datapath
    localparam bit HAS_WORD_OPS = (XLEN > 32);

    always_comb begin
        // all enables and flags low unless an opcode sets them
        ctrl         = '0;
        ctrl.imm_fmt = IMM_NONE;

        case (opcode)
            // upper immediates as x0 + imm in the ALU
            OP_LUI: begin
                ctrl.imm_fmt        = IMM_U;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
                ctrl.use_imm_alu    = 1'b1;
                ctrl.force_rs1_zero = 1'b1;
                ctrl.force_add      = 1'b1;
            end
            OP_AUIPC: begin
                // rs1 left alone and pc adder supplies the result
                ctrl.imm_fmt          = IMM_U;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
                ctrl.use_imm_alu      = 1'b1;
                ctrl.force_add        = 1'b1;
                ctrl.keep_pc_plus_imm = 1'b1;
            end

            // jumps
            OP_JAL: begin
                // only the return address is written
                ctrl.imm_fmt        = IMM_J;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b001;
                ctrl.use_imm_alu    = 1'b1;
                ctrl.force_rs1_zero = 1'b1;
                ctrl.force_add      = 1'b1;
            end
            OP_JALR: begin
                // target is rs1 + imm
                ctrl.imm_fmt     = IMM_I;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
                ctrl.use_imm_alu = 1'b1;
                ctrl.force_add   = 1'b1;
            end

            // rs1 compared with rs2 under funct3
            OP_BRANCH: begin
                ctrl.imm_fmt = IMM_B;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b110;
            end

            // memory ops with the ALU forming the address
            OP_LOAD: begin
                ctrl.imm_fmt     = IMM_I;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
                ctrl.use_imm_alu = 1'b1;
                ctrl.force_add   = 1'b1;
            end
            OP_STORE: begin
                // rs2 is the store data
                ctrl.imm_fmt     = IMM_S;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b110;
                ctrl.use_imm_alu = 1'b1;
                ctrl.force_add   = 1'b1;
            end

            // arithmetic with ALU codes passed through
            OP_OP_IMM: begin
                ctrl.imm_fmt     = IMM_I;
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
                ctrl.use_imm_alu = 1'b1;
            end
            OP_IMM_32: begin
                if (HAS_WORD_OPS) begin
                    ctrl.imm_fmt     = IMM_I;
                    {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b101;
                    ctrl.use_imm_alu = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_OP: begin
                {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b111;
            end
            OP_OP_32: begin
                if (HAS_WORD_OPS) begin
                    {ctrl.en_rs1, ctrl.en_rs2, ctrl.en_rd} = 3'b111;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end

            // fence and system decode to no enables and no imm
            OP_MISC_MEM, OP_SYSTEM: begin
                ctrl.imm_fmt = IMM_NONE;
            end

            // unknown opcode reported downstream
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: logic/decode_pkg.sv
// decode-side types
// immediate format enum, control record, decoded output record
package decode_pkg;

    import isa_pkg::*;

    // imm field width of the output record, independent of XLEN
    localparam int DEC_IMM_W = 64;

    // immediate layouts, none for register-only ops
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // control half of a decode, opcode only
    typedef struct packed {
        imm_fmt_e imm_fmt;
        logic     en_rs1;
        logic     en_rs2;
        logic     en_rd;
        logic     force_rs1_zero;   // rs1 read as x0
        logic     force_add;        // funct3 add, funct7 zero
        logic     use_imm_alu;      // ALU operand b is imm
        logic     keep_pc_plus_imm; // result taken from pc adder
        logic     illegal;
    } ctrl_t;

    // record handed to the next stage
    typedef struct packed {
        logic [DEC_IMM_W-1:0] imm;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rd;
        logic                 en_rs1;
        logic                 en_rs2;
        logic                 en_rd;
        logic [OPCODE_W-1:0]  op;
        logic [FUNCT3_W-1:0]  funct3;
        logic [FUNCT7_W-1:0]  funct7;
        logic                 use_imm_alu;
        logic                 keep_pc_plus_imm;
        logic                 illegal;
    } dec_out_t;

endpackage

// File: logic/decode_stage.sv
// registered decode stage
// ctrl_decode and imm_gen, override logic, output register
module decode_stage
    import isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  inst_t    inst,
    output logic     out_valid,
    output dec_out_t dec
);

    opcode_e         opcode;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    dec_out_t        dec_nxt;

    // raw opcode bits, unknown values included
    assign opcode = opcode_e'(inst.opcode);

    ctrl_decode #(
        .XLEN (XLEN)
    ) u_ctrl_decode (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    imm_gen #(
        .XLEN (XLEN)
    ) u_imm_gen (
        .inst (inst),
        .fmt  (ctrl.imm_fmt),
        .imm  (imm)
    );

    // assemble record, overrides as ctrl asks
    always_comb begin
        // widen to the record width, sign kept
        dec_nxt.imm = DEC_IMM_W'($signed(imm));

        dec_nxt.rs1 = ctrl.force_rs1_zero ? '0 : inst.rs1;
        dec_nxt.rs2 = inst.rs2;
        dec_nxt.rd  = inst.rd;

        dec_nxt.en_rs1 = ctrl.en_rs1;
        dec_nxt.en_rs2 = ctrl.en_rs2;
        dec_nxt.en_rd  = ctrl.en_rd;

        // ALU codes, add forced for address and upper-imm ops
        dec_nxt.op     = inst.opcode;
        dec_nxt.funct3 = ctrl.force_add ? F3_ADD_SUB : inst.funct3;
        dec_nxt.funct7 = ctrl.force_add ? '0 : inst.funct7;

        dec_nxt.use_imm_alu      = ctrl.use_imm_alu;
        dec_nxt.keep_pc_plus_imm = ctrl.keep_pc_plus_imm;
        dec_nxt.illegal          = ctrl.illegal;
    end

    // one-cycle pipe, record held between strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            dec       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                dec <= dec_nxt;
            end
        end
    end

    // every strobe reappears exactly one edge later
    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (out_valid == $past(in_valid)));

    // illegal ops must never reach hazard or writeback logic
    a_illegal_no_regs: assert property (@(posedge clk) disable iff (rst)
        (out_valid && dec.illegal) |-> !(dec.en_rs1 || dec.en_rs2 || dec.en_rd));

endmodule

// File: logic/imm_gen.sv
// immediate generator
// unscrambles I, S, B, U and J immediates and sign-extends to XLEN
module imm_gen
    import isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  inst_t          inst,
    input  imm_fmt_e       fmt,
    output logic [XLEN-1:0] imm
);

    logic [INST_W-1:0] w;     // raw word, format-free bit access
    logic              sgn;   // sign always sits in bit 31
    logic [31:0]       imm32;

    assign w   = inst;
    assign sgn = w[31];

    // build 32-bit form first, widen once below
    always_comb begin
        case (fmt)
            // 12 bits straight from the top
            IMM_I: imm32 = {{20{sgn}}, w[31:20]};

            // split around rd position
            IMM_S: imm32 = {{20{sgn}}, w[31:25], w[11:7]};

            // 13-bit halfword offset
            IMM_B: imm32 = {{19{sgn}}, w[31], w[7], w[30:25], w[11:8], 1'b0};

            // upper 20, low 12 zero
            IMM_U: imm32 = {w[31:12], 12'b0};

            // 21-bit halfword offset
            IMM_J: imm32 = {{11{sgn}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

            default: imm32 = '0;
        endcase
    end

    // signed size cast replicates bit 31 up to XLEN
    assign imm = XLEN'($signed(imm32));

    // branch and jump targets stay halfword aligned
    always_comb begin
        if (fmt == IMM_B || fmt == IMM_J) begin
            assert (imm[0] == 1'b0)
                else $error("imm_gen: odd offset for format %s", fmt.name());
        end
    end

endmodule

// File: logic/isa_pkg.sv
// instruction-set constants for the RV64I decode stage
// field widths, major opcode enum, funct3 add code
// R-type instruction word layout
package isa_pkg;

    // word and field widths
    localparam int INST_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;

    // major opcodes, bits 6:0 of the word
    // low two bits are always 11 for 32-bit encodings
    typedef enum logic [OPCODE_W-1:0] {
        // loads and fences
        OP_LOAD     = 7'b000_0011,
        OP_MISC_MEM = 7'b000_1111,

        // integer register-immediate
        OP_OP_IMM   = 7'b001_0011,
        OP_AUIPC    = 7'b001_0111,
        OP_IMM_32   = 7'b001_1011,

        // stores and register-register
        OP_STORE    = 7'b010_0011,
        OP_OP       = 7'b011_0011,
        OP_LUI      = 7'b011_0111,
        OP_OP_32    = 7'b011_1011,

        // control transfer
        OP_BRANCH   = 7'b110_0011,
        OP_JALR     = 7'b110_0111,
        OP_JAL      = 7'b110_1111,

        // ecall, ebreak, csr access
        OP_SYSTEM   = 7'b111_0011
    } opcode_e;

    // funct3 of add/sub
    // ALU falls back to this when it only forms a sum or an address
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;

    // R-type view of the word, msb first
    // other formats reuse the same bit positions
    typedef struct packed {
        logic [FUNCT7_W-1:0]  funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [FUNCT3_W-1:0]  funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [OPCODE_W-1:0]  opcode;
    } inst_t;

endpackage

// File: rv64_decode.f
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/imm_gen.sv
logic/ctrl_decode.sv
logic/decode_stage.sv
test/tb_clock.sv
test/tb_decode_stage.sv

// File: test/tb_clock.sv
// testbench clock source
// free-running clk, period set by parameter
module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    // start low, first rising edge at half a period
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: test/tb_decode_stage.sv
// testbench for decode_stage
// directed and random stimulus, reference decode, comparison process
// per-test result lines, closing counts, cycle-limit timeout
module tb_decode_stage
    import isa_pkg::*, decode_pkg::*;
();

    // run lengths, also size the timeout
    localparam int RESET_CYCLES   = 5;
    localparam int N_IDLE_START   = 4;
    localparam int N_DIRECTED     = 26;
    localparam int N_ILLEGAL      = 16;
    localparam int N_RANDOM       = 300;
    localparam int N_RESET_STREAM = 40;
    localparam int DRAIN          = 3;
    localparam int MAX_CYCLES     = RESET_CYCLES + N_IDLE_START + N_DIRECTED + N_ILLEGAL
                                    + 2 * N_RANDOM + N_RESET_STREAM + 2 + 5 * DRAIN + 50;

    logic     clk;
    logic     rst;
    logic     in_valid;
    inst_t    inst;
    logic     out_valid;
    dec_out_t dec;

    integer   seed;
    int       errors;
    int       checks;
    int       tests_run;
    int       tests_failed;
    int       test_err_base;
    int       cycle_count;

    // comparison state
    dec_out_t expect_q[$];
    dec_out_t exp_dec;
    dec_out_t hold_dec;
    logic     exp_valid;
    logic     armed;

    opcode_e known_ops[13] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                               OP_STORE, OP_OP_IMM, OP_IMM_32, OP_OP, OP_OP_32,
                               OP_MISC_MEM, OP_SYSTEM};
    // unknown majors, some with low bits other than 11
    logic [6:0] bad_ops[8] = '{7'h00, 7'h7f, 7'h2b, 7'h53, 7'h02, 7'h31, 7'h6c, 7'h1e};

    tb_clock #(
        .PERIOD (10)
    ) u_clock (
        .clk (clk)
    );

    decode_stage #(
        .XLEN (64)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst      (inst),
        .out_valid (out_valid),
        .dec       (dec)
    );

    // expected record from the RV64I encoding rules
    function automatic dec_out_t ref_decode(input inst_t w);
        dec_out_t    r;
        logic [31:0] b;
        imm_fmt_e    fmt;
        logic [2:0]  en;
        logic        zero_rs1;
        logic        add;
        logic        imm_alu;
        logic        pc_imm;
        logic        bad;
        logic [63:0] imm;
        begin
            b = w;
            fmt = IMM_NONE;
            en = 3'b000;
            zero_rs1 = 1'b0;
            add = 1'b0;
            imm_alu = 1'b0;
            pc_imm = 1'b0;
            bad = 1'b0;
            case (w.opcode)
                OP_LUI: begin
                    fmt = IMM_U;
                    en = 3'b001;
                    {imm_alu, zero_rs1, add} = 3'b111;
                end
                OP_AUIPC: begin
                    fmt = IMM_U;
                    en = 3'b001;
                    {imm_alu, add, pc_imm} = 3'b111;
                end
                OP_JAL: begin
                    fmt = IMM_J;
                    en = 3'b001;
                    {imm_alu, zero_rs1, add} = 3'b111;
                end
                OP_JALR, OP_LOAD: begin
                    fmt = IMM_I;
                    en = 3'b101;
                    {imm_alu, add} = 2'b11;
                end
                OP_BRANCH: begin
                    fmt = IMM_B;
                    en = 3'b110;
                end
                OP_STORE: begin
                    fmt = IMM_S;
                    en = 3'b110;
                    {imm_alu, add} = 2'b11;
                end
                OP_OP_IMM, OP_IMM_32: begin
                    fmt = IMM_I;
                    en = 3'b101;
                    imm_alu = 1'b1;
                end
                OP_OP, OP_OP_32: en = 3'b111;
                OP_MISC_MEM, OP_SYSTEM: en = 3'b000;
                default: bad = 1'b1;
            endcase
            // immediates, sign from bit 31
            case (fmt)
                IMM_I: imm = {{52{b[31]}}, b[31:20]};
                IMM_S: imm = {{52{b[31]}}, b[31:25], b[11:7]};
                IMM_B: imm = {{51{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
                IMM_U: imm = {{32{b[31]}}, b[31:12], 12'h000};
                IMM_J: imm = {{43{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
                default: imm = 64'd0;
            endcase
            r = '0;
            r.imm = imm;
            r.rs1 = zero_rs1 ? 5'd0 : w.rs1;
            r.rs2 = w.rs2;
            r.rd = w.rd;
            {r.en_rs1, r.en_rs2, r.en_rd} = en;
            r.op = w.opcode;
            r.funct3 = add ? 3'b000 : w.funct3;
            r.funct7 = add ? 7'd0 : w.funct7;
            r.use_imm_alu = imm_alu;
            r.keep_pc_plus_imm = pc_imm;
            r.illegal = bad;
            return r;
        end
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s mismatch, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // compares each edge, records the strobe for the next one
    always @(posedge clk) begin
        if (armed) begin
            exp_valid = (expect_q.size() != 0);
            check(128'(out_valid), 128'(exp_valid), "out_valid");
            if (exp_valid) begin
                exp_dec = expect_q.pop_front();
            end
            if (exp_valid && out_valid) begin
                check(128'(dec), 128'(exp_dec), "dec");
                hold_dec = exp_dec;
            end else if (!out_valid) begin
                // record holds between strobes
                check(128'(dec), 128'(hold_dec), "held dec");
            end
        end
        if (rst) begin
            expect_q.delete();
            hold_dec = '0;
            armed = 1'b1;
        end else if (in_valid) begin
            expect_q.push_back(ref_decode(inst));
        end
    end

    // hang guard
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("simulation timed out after %0d cycles", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    // drive after the edge, inputs stable for the next one
    task automatic send(input inst_t w);
        in_valid = 1'b1;
        inst = w;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // random word, mostly a known opcode
    task automatic rand_inst(output inst_t w);
        logic [31:0] r;
        logic [31:0] pick;
        int          idx;
        r = $random(seed);
        pick = $random(seed);
        idx = int'(pick[7:4]) % 13;
        if (pick[1:0] != 2'b00) begin
            r[6:0] = known_ops[idx];
        end
        w = r;
    endtask

    task automatic end_test(input string name);
        idle(DRAIN);
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    initial begin
        inst_t       w;
        logic [31:0] r;
        logic [31:0] gap;
        seed = 78;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_err_base = 0;
        armed = 1'b0;
        hold_dec = '0;
        rst = 1'b1;
        in_valid = 1'b0;
        inst = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet after reset
        idle(N_IDLE_START);
        end_test("idle after reset");

        // each known opcode, sign bit clear then set
        for (int k = 0; k < 13; k++) begin
            for (int s = 0; s < 2; s++) begin
                r = $random(seed);
                r[31] = s[0];
                r[6:0] = known_ops[k];
                send(r);
            end
        end
        end_test("directed opcodes");

        for (int k = 0; k < 8; k++) begin
            for (int s = 0; s < 2; s++) begin
                r = $random(seed);
                r[31] = s[0];
                r[6:0] = bad_ops[k];
                send(r);
            end
        end
        end_test("illegal opcodes");

        // back to back with the odd gap
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_inst(w);
            send(w);
            gap = $random(seed);
            if (gap[1:0] == 2'b00) begin
                idle(1);
            end
        end
        end_test("random stream");

        // reset lands on a live strobe
        for (int i = 0; i < N_RESET_STREAM / 2; i++) begin
            rand_inst(w);
            send(w);
        end
        rst = 1'b1;
        rand_inst(w);
        send(w);
        idle(1);
        rst = 1'b0;
        for (int i = 0; i < N_RESET_STREAM / 2; i++) begin
            rand_inst(w);
            send(w);
        end
        end_test("reset mid-stream");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
